// ==== design/rv_alu.sv ====
// Combinational ALU
// Add, subtract, logic, set-less-than and shifts
`timescale 1ns/1ps

module rv_alu (
	input  rv_pkg::word_t   op_a,
	input  rv_pkg::word_t   op_b,
	input  rv_pkg::alu_op_t op,
	output rv_pkg::word_t   result
);

	logic [4:0] shamt;

	assign shamt = op_b[4:0]; // Only low 5 bits shift

	always_comb begin
		case (op)
			rv_pkg::ALU_ADD:  result = op_a + op_b;
			rv_pkg::ALU_SUB:  result = op_a - op_b;
			rv_pkg::ALU_AND:  result = op_a & op_b;
			rv_pkg::ALU_OR:   result = op_a | op_b;
			rv_pkg::ALU_XOR:  result = op_a ^ op_b;
			rv_pkg::ALU_SLT:  result = {31'b0, $signed(op_a) < $signed(op_b)};
			rv_pkg::ALU_SLTU: result = {31'b0, op_a < op_b};
			rv_pkg::ALU_SLL:  result = op_a << shamt;
			rv_pkg::ALU_SRL:  result = op_a >> shamt;
			rv_pkg::ALU_SRA:  result = $signed(op_a) >>> shamt; // Sign fill
			default:          result = '0;
		endcase
	end

	// Decoder in the core must only ever select a defined operation
	always_comb begin
		assert (op <= rv_pkg::ALU_SRA)
			else $error("rv_alu: undefined op code %0d", op);
	end

endmodule

// ==== design/rv_comparator.sv ====
// Branch comparator
// Equal, signed less-than, unsigned less-than
`timescale 1ns/1ps

module rv_comparator (
	input  rv_pkg::word_t   in_a,
	input  rv_pkg::word_t   in_b,
	input  rv_pkg::cmp_op_t op,
	output logic            taken
);

	// Negated forms (BNE, BGE, BGEU) are handled by the core
	always_comb begin
		case (op)
			rv_pkg::CMP_EQ:  taken = (in_a == in_b);
			rv_pkg::CMP_LT:  taken = ($signed(in_a) < $signed(in_b));
			rv_pkg::CMP_LTU: taken = (in_a < in_b);
			default:         taken = 1'b0;
		endcase
	end

endmodule

// ==== design/rv_core.sv ====
// Multi-cycle RV32I core
// Fetch/decode/execute/memory FSM, decoder, immediates, next PC, retire trace
`timescale 1ns/1ps

module rv_core #(
	parameter rv_pkg::word_t reset_pc = 32'h0000_0000
) (
	input  logic              clock,
	input  logic              reset,
	output rv_pkg::word_t     iaddr,
	input  rv_pkg::word_t     idata,
	output logic              ivalid,
	input  logic              iready,
	output rv_pkg::word_t     daddr,
	output rv_pkg::word_t     dwdata,
	input  rv_pkg::word_t     drdata,
	output logic              dwrite,
	output logic              dvalid,
	input  logic              dready,
	output logic              retire,
	output rv_pkg::word_t     retire_pc,
	output rv_pkg::reg_addr_t retire_rd,
	output rv_pkg::word_t     retire_data,
	output logic              retire_wen
);

	typedef enum logic [2:0] {
		FETCH,
		DECODE,
		EXECUTE,
		MEM_READ,
		MEM_WRITE
	} state_t;

	state_t            state;
	rv_pkg::word_t     pc;
	rv_pkg::word_t     pc_plus4;
	rv_pkg::word_t     pc_next;
	rv_pkg::word_t     instr;
	rv_pkg::word_t     imm;      // Registered in DECODE
	rv_pkg::word_t     imm_dec;
	rv_pkg::word_t     rs1_data;
	rv_pkg::word_t     rs2_data;
	rv_pkg::word_t     rd_data;
	logic              rd_wen;
	rv_pkg::word_t     alu_a;
	rv_pkg::word_t     alu_b;
	rv_pkg::word_t     alu_result;
	rv_pkg::alu_op_t   alu_op;
	rv_pkg::cmp_op_t   cmp_op;
	logic              cmp_taken;
	logic              branch_taken;
	logic [6:0]        opcode;
	logic [2:0]        funct3;
	rv_pkg::reg_addr_t rd;
	logic is_lui, is_auipc, is_jal, is_jalr, is_branch;
	logic is_load, is_store, is_op, is_opimm;
	logic writes_rd;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign rd     = instr[11:7];

	assign is_lui    = (opcode == rv_pkg::OPC_LUI);
	assign is_auipc  = (opcode == rv_pkg::OPC_AUIPC);
	assign is_jal    = (opcode == rv_pkg::OPC_JAL);
	assign is_jalr   = (opcode == rv_pkg::OPC_JALR);
	assign is_branch = (opcode == rv_pkg::OPC_BRANCH);
	assign is_load   = (opcode == rv_pkg::OPC_LOAD);
	assign is_store  = (opcode == rv_pkg::OPC_STORE);
	assign is_op     = (opcode == rv_pkg::OPC_OP);
	assign is_opimm  = (opcode == rv_pkg::OPC_OPIMM);
	assign writes_rd = is_lui | is_auipc | is_jal | is_jalr | is_load | is_op | is_opimm;

	// Immediate per instruction format
	always_comb begin
		case (opcode)
			rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC:
				imm_dec = {instr[31:12], 12'b0};
			rv_pkg::OPC_JAL:
				imm_dec = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
			rv_pkg::OPC_BRANCH:
				imm_dec = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
			rv_pkg::OPC_STORE:
				imm_dec = {{21{instr[31]}}, instr[30:25], instr[11:7]};
			default: // I-type
				imm_dec = {{21{instr[31]}}, instr[30:20]};
		endcase
	end

	// ALU operation from funct3 and funct7 bit 5
	always_comb begin
		alu_op = rv_pkg::ALU_ADD; // Address and target sums
		if (is_op || is_opimm) begin
			case (funct3)
				3'b000: alu_op = (is_op && instr[30]) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
				3'b001: alu_op = rv_pkg::ALU_SLL;
				3'b010: alu_op = rv_pkg::ALU_SLT;
				3'b011: alu_op = rv_pkg::ALU_SLTU;
				3'b100: alu_op = rv_pkg::ALU_XOR;
				3'b101: alu_op = instr[30] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
				3'b110: alu_op = rv_pkg::ALU_OR;
				3'b111: alu_op = rv_pkg::ALU_AND;
			endcase
		end
	end

	// PC-relative forms add to pc, LUI adds to zero
	assign alu_a = (is_auipc || is_jal || is_branch) ? pc :
		is_lui ? '0 : rs1_data;
	assign alu_b = is_op ? rs2_data : imm;

	rv_alu u_alu (
		.op_a   (alu_a),
		.op_b   (alu_b),
		.op     (alu_op),
		.result (alu_result)
	);

	// funct3[2:1] picks the compare, funct3[0] inverts it
	assign cmp_op = (funct3[2:1] == 2'b10) ? rv_pkg::CMP_LT :
		(funct3[2:1] == 2'b11) ? rv_pkg::CMP_LTU : rv_pkg::CMP_EQ;

	rv_comparator u_comp (
		.in_a  (rs1_data),
		.in_b  (rs2_data),
		.op    (cmp_op),
		.taken (cmp_taken)
	);

	assign branch_taken = is_branch && (cmp_taken ^ funct3[0]);

	assign pc_plus4 = pc + 32'd4;

	always_comb begin
		if (is_jalr) begin
			pc_next = {alu_result[31:1], 1'b0};
		end else if (is_jal || branch_taken) begin
			pc_next = alu_result;
		end else begin
			pc_next = pc_plus4;
		end
	end

	// Retire in EXECUTE, or at the end of the memory access
	assign retire = (state == EXECUTE && !is_load && !is_store) ||
		((state == MEM_READ || state == MEM_WRITE) && dready);

	assign rd_data = (is_jal || is_jalr) ? pc_plus4 : is_load ? drdata : alu_result;
	assign rd_wen  = retire && writes_rd && (rd != '0);

	rv_regfile u_regfile (
		.clock   (clock),
		.reset   (reset),
		.ra_addr (instr[19:15]),
		.ra_data (rs1_data),
		.rb_addr (instr[24:20]),
		.rb_data (rs2_data),
		.rd_addr (rd),
		.rd_data (rd_data),
		.rd_wen  (rd_wen)
	);

	always_ff @(posedge clock) begin
		if (reset) begin
			state  <= FETCH;
			ivalid <= 1'b0;
			pc     <= reset_pc;
		end else begin
			case (state)
				FETCH: begin
					if (!ivalid) begin
						ivalid <= 1'b1; // First fetch after reset
					end else if (iready) begin
						ivalid <= 1'b0;
						state  <= DECODE;
					end
				end
				DECODE: state <= EXECUTE;
				EXECUTE: begin
					if (is_load) begin
						state <= MEM_READ;
					end else if (is_store) begin
						state <= MEM_WRITE;
					end else begin
						state  <= FETCH;
						ivalid <= 1'b1;
					end
				end
				MEM_READ, MEM_WRITE: begin
					if (dready) begin
						state  <= FETCH;
						ivalid <= 1'b1;
					end
				end
				default: state <= FETCH;
			endcase
			if (retire) begin
				pc <= pc_next;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (ivalid && iready) begin
			instr <= idata;
		end
		if (state == DECODE) begin
			imm <= imm_dec;
		end
	end

	assign iaddr  = pc;
	assign dvalid = (state == MEM_READ || state == MEM_WRITE);
	assign dwrite = (state == MEM_WRITE);
	assign daddr  = alu_result; // rs1 + offset
	assign dwdata = rs2_data;

	assign retire_pc   = pc;
	assign retire_rd   = rd;
	assign retire_data = rd_data;
	assign retire_wen  = rd_wen;

	// One instruction in flight, so the two buses never overlap
	a_bus_exclusive: assert property (@(posedge clock) disable iff (reset)
		!(ivalid && dvalid));

endmodule

// ==== design/rv_pkg.sv ====
// Shared data types for the RV32I subsystem
// ALU and comparator operation codes, base opcode values
package rv_pkg;

	// Data word, byte address and instruction
	typedef logic [31:0] word_t;

	// Register index x0..x31
	typedef logic [4:0] reg_addr_t;

	// ALU operation selector
	typedef logic [3:0] alu_op_t;

	// Branch comparator selector
	typedef logic [1:0] cmp_op_t;

	localparam alu_op_t ALU_ADD  = 4'd0;
	localparam alu_op_t ALU_SUB  = 4'd1;
	localparam alu_op_t ALU_AND  = 4'd2;
	localparam alu_op_t ALU_OR   = 4'd3;
	localparam alu_op_t ALU_XOR  = 4'd4;
	localparam alu_op_t ALU_SLT  = 4'd5;
	localparam alu_op_t ALU_SLTU = 4'd6;
	localparam alu_op_t ALU_SLL  = 4'd7;
	localparam alu_op_t ALU_SRL  = 4'd8;
	localparam alu_op_t ALU_SRA  = 4'd9; // Highest defined code

	localparam cmp_op_t CMP_EQ  = 2'd0;
	localparam cmp_op_t CMP_LT  = 2'd1; // Signed
	localparam cmp_op_t CMP_LTU = 2'd2; // Unsigned

	// Base opcodes, instruction bits 6:0
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;

endpackage

// ==== design/rv_ram.sv ====
// Word-addressed local memory
// Instruction port, data port, preload port
`timescale 1ns/1ps

module rv_ram #(
	parameter int mem_words = 256
) (
	input  logic          clock,
	input  logic          reset,
	input  rv_pkg::word_t iaddr,
	input  logic          ivalid,
	output rv_pkg::word_t idata,
	output logic          iready,
	input  rv_pkg::word_t daddr,
	input  rv_pkg::word_t dwdata,
	input  logic          dwrite,
	input  logic          dvalid,
	output rv_pkg::word_t drdata,
	output logic          dready,
	input  logic          load_en,
	input  rv_pkg::word_t load_addr,
	input  rv_pkg::word_t load_data
);

	localparam int aw = $clog2(mem_words);

	rv_pkg::word_t mem [mem_words];
	logic [aw-1:0] i_index;
	logic [aw-1:0] d_index;

	assign i_index = iaddr[aw+1:2]; // Byte address to word index
	assign d_index = daddr[aw+1:2];

	// One-cycle ready pulse per request
	always_ff @(posedge clock) begin
		if (reset) begin
			iready <= 1'b0;
			dready <= 1'b0;
		end else begin
			iready <= ivalid && !iready;
			dready <= dvalid && !dready;
		end
	end

	always_ff @(posedge clock) begin
		if (load_en) begin
			mem[load_addr[aw-1:0]] <= load_data;
		end else if (dvalid && dwrite && !dready) begin
			mem[d_index] <= dwdata;
		end
		if (ivalid && !iready) begin
			idata <= mem[i_index];
		end
		if (dvalid && !dready) begin
			drdata <= mem[d_index];
		end
	end

	a_in_range: assert property (@(posedge clock) disable iff (reset)
		(ivalid |-> iaddr[31:2] < mem_words) and (dvalid |-> daddr[31:2] < mem_words));

endmodule

// ==== design/rv_regfile.sv ====
// Integer register file
// 32 words, two combinational reads, one synchronous write
`timescale 1ns/1ps

module rv_regfile (
	input  logic              clock,
	input  logic              reset,
	input  rv_pkg::reg_addr_t ra_addr,
	output rv_pkg::word_t     ra_data,
	input  rv_pkg::reg_addr_t rb_addr,
	output rv_pkg::word_t     rb_data,
	input  rv_pkg::reg_addr_t rd_addr,
	input  rv_pkg::word_t     rd_data,
	input  logic              rd_wen
);

	rv_pkg::word_t regs [32];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (rd_wen && rd_addr != '0) begin // x0 stays zero
			regs[rd_addr] <= rd_data;
		end
	end

	assign ra_data = regs[ra_addr];
	assign rb_data = regs[rb_addr];

	// x0 must never pick up a write from the core
	a_x0_zero: assert property (@(posedge clock) disable iff (reset)
		(ra_addr == '0 |-> ra_data == '0) and (rb_addr == '0 |-> rb_data == '0));

endmodule

// ==== design/rv_system.sv ====
// Subsystem top level
// Core and local memory
`timescale 1ns/1ps

module rv_system #(
	parameter rv_pkg::word_t reset_pc  = 32'h0000_0000,
	parameter int            mem_words = 256
) (
	input  logic              clock,
	input  logic              reset,
	input  logic              load_en,
	input  rv_pkg::word_t     load_addr,
	input  rv_pkg::word_t     load_data,
	output logic              retire,
	output rv_pkg::word_t     retire_pc,
	output rv_pkg::reg_addr_t retire_rd,
	output rv_pkg::word_t     retire_data,
	output logic              retire_wen
);

	// Instruction bus
	rv_pkg::word_t iaddr;
	rv_pkg::word_t idata;
	logic          ivalid;
	logic          iready;

	// Data bus
	rv_pkg::word_t daddr;
	rv_pkg::word_t dwdata;
	rv_pkg::word_t drdata;
	logic          dwrite;
	logic          dvalid;
	logic          dready;

	rv_core #(
		.reset_pc (reset_pc)
	) u_core (
		.clock       (clock),
		.reset       (reset),
		.iaddr       (iaddr),
		.idata       (idata),
		.ivalid      (ivalid),
		.iready      (iready),
		.daddr       (daddr),
		.dwdata      (dwdata),
		.drdata      (drdata),
		.dwrite      (dwrite),
		.dvalid      (dvalid),
		.dready      (dready),
		.retire      (retire),
		.retire_pc   (retire_pc),
		.retire_rd   (retire_rd),
		.retire_data (retire_data),
		.retire_wen  (retire_wen)
	);

	rv_ram #(
		.mem_words (mem_words)
	) u_ram (
		.clock     (clock),
		.reset     (reset),
		.iaddr     (iaddr),
		.ivalid    (ivalid),
		.idata     (idata),
		.iready    (iready),
		.daddr     (daddr),
		.dwdata    (dwdata),
		.dwrite    (dwrite),
		.dvalid    (dvalid),
		.drdata    (drdata),
		.dready    (dready),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data)
	);

endmodule

// ==== files.f ====
design/rv_pkg.sv
design/rv_alu.sv
design/rv_comparator.sv
design/rv_regfile.sv
design/rv_core.sv
design/rv_ram.sv
design/rv_system.sv
testbench/tb_system.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the RV32I subsystem testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_system \
	-o sim_tb > build.log 2>&1 \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	|| echo "Build or simulation returned an error, see build.log and sim.log"

grep -q "Test completed successfully" sim.log 2>/dev/null \
	&& echo "PASS" && exit 0 \
	|| { echo "FAIL"; exit 1; }

// ==== testbench/tb_system.sv ====
// Directed testbench for the RV32I subsystem
// Instruction encoders, LFSR stimulus, retire checks and watchdog
`timescale 1ns/1ps

module tb_system;

	localparam int instr_count   = 49; // Retires checked over all tests
	localparam int margin_cycles = 150; // Reset and preload time

	logic                clock;
	logic                reset;
	logic                load_en;
	rv_pkg::word_t       load_addr;
	rv_pkg::word_t       load_data;
	logic                retire;
	rv_pkg::word_t       retire_pc;
	rv_pkg::reg_addr_t   retire_rd;
	rv_pkg::word_t       retire_data;
	logic                retire_wen;

	rv_pkg::word_t       prog[$];
	rv_pkg::word_t       lfsr = 32'h38fd;
	string               test_name;

	rv_system #(
		.reset_pc  (32'h0000_0000),
		.mem_words (256)
	) dut0 (
		.clock       (clock),
		.reset       (reset),
		.load_en     (load_en),
		.load_addr   (load_addr),
		.load_data   (load_data),
		.retire      (retire),
		.retire_pc   (retire_pc),
		.retire_rd   (retire_rd),
		.retire_data (retire_data),
		.retire_wen  (retire_wen)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// Fibonacci LFSR with taps 32 22 2 1 and one step per bit
	function automatic rv_pkg::word_t take_bits(int n);
		rv_pkg::word_t v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic rv_pkg::word_t sext12(logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	function automatic rv_pkg::word_t enc_r(logic alt, rv_pkg::reg_addr_t rs2,
		rv_pkg::reg_addr_t rs1, logic [2:0] f3, rv_pkg::reg_addr_t rd);
		return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
	endfunction

	function automatic rv_pkg::word_t enc_i(logic [11:0] imm, rv_pkg::reg_addr_t rs1,
		logic [2:0] f3, rv_pkg::reg_addr_t rd, logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic rv_pkg::word_t enc_s(logic [11:0] imm, rv_pkg::reg_addr_t rs2,
		rv_pkg::reg_addr_t rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::OPC_STORE};
	endfunction

	function automatic rv_pkg::word_t enc_b(logic [12:0] off, rv_pkg::reg_addr_t rs2,
		rv_pkg::reg_addr_t rs1, logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::OPC_BRANCH};
	endfunction

	function automatic rv_pkg::word_t enc_u(logic [19:0] imm, rv_pkg::reg_addr_t rd,
		logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic rv_pkg::word_t enc_j(logic [20:0] off, rv_pkg::reg_addr_t rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::OPC_JAL};
	endfunction

	// RV32I register-register results by funct3 and funct7 bit 5
	function automatic rv_pkg::word_t reference_rop(logic [2:0] f3, logic alt,
		rv_pkg::word_t a, rv_pkg::word_t b);
		logic [4:0] s;
		s = b[4:0];
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << s;
			3'd2: return ((a[31] != b[31]) ? a[31] : (a < b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: return alt ? ((a >> s) | (a[31] ? ~(32'hffff_ffff >> s) : 32'd0)) : a >> s;
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic check_value(string name, rv_pkg::word_t expected, rv_pkg::word_t actual);
		if (actual !== expected) begin
			$display("** Error: %s expected 0x%08h got 0x%08h in %s test",
				name, expected, actual, test_name);
			$display("Test failed");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	// Preload the program while reset is held for at least 5 cycles
	task automatic run_program();
		int n;
		@(posedge clock);
		reset <= 1'b1;
		n = 0;
		while (n < prog.size() || n < 5) begin
			if (n < prog.size()) begin
				load_en   <= 1'b1;
				load_addr <= n;
				load_data <= prog[n];
			end else begin
				load_en <= 1'b0;
			end
			n++;
			@(posedge clock);
		end
		load_en <= 1'b0;
		reset   <= 1'b0;
	endtask

	task automatic capture_retire(output rv_pkg::word_t pc, output rv_pkg::reg_addr_t rd,
		output rv_pkg::word_t data, output logic wen);
		do begin
			@(negedge clock); // Trace outputs are stable mid-cycle
		end while (!retire);
		pc   = retire_pc;
		rd   = retire_rd;
		data = retire_data;
		wen  = retire_wen;
	endtask

	task automatic expect_write(rv_pkg::word_t pc, rv_pkg::reg_addr_t rd, rv_pkg::word_t data);
		rv_pkg::word_t     c_pc;
		rv_pkg::reg_addr_t c_rd;
		rv_pkg::word_t     c_data;
		logic              c_wen;
		capture_retire(c_pc, c_rd, c_data, c_wen);
		check_value("retire_pc", pc, c_pc);
		check_value("retire_rd", {27'b0, rd}, {27'b0, c_rd});
		check_value("retire_data", data, c_data);
		check_value("retire_wen", 32'd1, {31'b0, c_wen});
	endtask

	// Stores, branches and writes to x0
	task automatic expect_no_write(rv_pkg::word_t pc);
		rv_pkg::word_t     c_pc;
		rv_pkg::reg_addr_t c_rd;
		rv_pkg::word_t     c_data;
		logic              c_wen;
		capture_retire(c_pc, c_rd, c_data, c_wen);
		check_value("retire_pc", pc, c_pc);
		check_value("retire_wen", 32'd0, {31'b0, c_wen});
	endtask

	task automatic test_arith();
		logic [11:0]   imm_a;
		logic [11:0]   imm_b;
		logic [2:0]    f3_list [10];
		logic          alt_list [10];
		rv_pkg::word_t a;
		rv_pkg::word_t b;
		test_name = "arith";
		// ADD SUB AND OR XOR SLT SLTU SLL SRL SRA
		f3_list  = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd4, 3'd2, 3'd3, 3'd1, 3'd5, 3'd5};
		alt_list = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
		// Negative a and positive b split SLT from SLTU and SRA from SRL
		imm_a = 12'(take_bits(11)) | 12'h800;
		imm_b = 12'(take_bits(11)) | 12'd1; // Nonzero shift amount
		prog.delete();
		prog.push_back(enc_i(imm_a, 5'd0, 3'd0, 5'd1, rv_pkg::OPC_OPIMM));
		prog.push_back(enc_i(imm_b, 5'd0, 3'd0, 5'd2, rv_pkg::OPC_OPIMM));
		for (int i = 0; i < 10; i++) begin
			prog.push_back(enc_r(alt_list[i], 5'd2, 5'd1, f3_list[i], 5'(4 + i)));
		end
		prog.push_back(enc_j(21'd0, 5'd0)); // Park in a self loop
		run_program();
		a = sext12(imm_a);
		b = sext12(imm_b);
		expect_write(32'd0, 5'd1, a);
		expect_write(32'd4, 5'd2, b);
		for (int i = 0; i < 10; i++) begin
			expect_write(32'(8 + 4 * i), 5'(4 + i), reference_rop(f3_list[i], alt_list[i], a, b));
		end
	endtask

	task automatic test_memory();
		rv_pkg::word_t w;
		logic [11:0]   lo;
		logic [19:0]   hi;
		logic [11:0]   off;
		test_name = "memory";
		w   = take_bits(32);
		lo  = w[11:0];
		hi  = 20'((w - sext12(lo)) >> 12);
		off = 12'(take_bits(5) << 2); // Word aligned offset inside memory
		prog.delete();
		prog.push_back(enc_i(12'h200, 5'd0, 3'd0, 5'd1, rv_pkg::OPC_OPIMM));
		prog.push_back(enc_u(hi, 5'd2, rv_pkg::OPC_LUI));
		prog.push_back(enc_i(lo, 5'd2, 3'd0, 5'd2, rv_pkg::OPC_OPIMM));
		prog.push_back(enc_s(off, 5'd2, 5'd1));
		prog.push_back(enc_i(off, 5'd1, 3'b010, 5'd3, rv_pkg::OPC_LOAD));
		prog.push_back(enc_j(21'd0, 5'd0));
		run_program();
		expect_write(32'd0, 5'd1, 32'h200);
		expect_write(32'd4, 5'd2, {hi, 12'b0});
		expect_write(32'd8, 5'd2, w);
		expect_no_write(32'd12);
		expect_write(32'd16, 5'd3, w);
	endtask

	task automatic test_branches();
		logic [2:0]        f3_list [12];
		rv_pkg::reg_addr_t rs1_list [12];
		rv_pkg::reg_addr_t rs2_list [12];
		logic              taken_list [12];
		rv_pkg::word_t     p;
		rv_pkg::word_t     q;
		rv_pkg::word_t     pc;
		test_name = "branch";
		// Positive x1 and negative x2 let each branch be taken once and then not taken
		f3_list    = '{3'd0, 3'd0, 3'd1, 3'd1, 3'd4, 3'd4, 3'd5, 3'd5, 3'd6, 3'd6, 3'd7, 3'd7};
		rs1_list   = '{5'd1, 5'd1, 5'd1, 5'd1, 5'd2, 5'd1, 5'd1, 5'd2, 5'd1, 5'd2, 5'd2, 5'd1};
		rs2_list   = '{5'd1, 5'd2, 5'd2, 5'd1, 5'd1, 5'd2, 5'd2, 5'd1, 5'd2, 5'd1, 5'd1, 5'd2};
		taken_list = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
		p = take_bits(10) + 32'd1;
		q = take_bits(10) + 32'd1;
		prog.delete();
		prog.push_back(enc_i(12'(p), 5'd0, 3'd0, 5'd1, rv_pkg::OPC_OPIMM));
		prog.push_back(enc_i(12'(32'd0 - q), 5'd0, 3'd0, 5'd2, rv_pkg::OPC_OPIMM));
		for (int i = 0; i < 12; i++) begin
			prog.push_back(enc_b(13'd8, rs2_list[i], rs1_list[i], f3_list[i]));
			prog.push_back(enc_i(12'd0, 5'd0, 3'd0, 5'd0, rv_pkg::OPC_OPIMM)); // NOP
		end
		prog.push_back(enc_j(21'd0, 5'd0));
		run_program();
		expect_write(32'd0, 5'd1, p);
		expect_write(32'd4, 5'd2, 32'd0 - q);
		pc = 32'd8;
		for (int i = 0; i < 12; i++) begin
			expect_no_write(pc);
			if (!taken_list[i]) begin
				expect_no_write(pc + 32'd4); // Fall through into the NOP
			end
			pc = pc + 32'd8;
		end
		expect_no_write(pc);
	endtask

	task automatic test_jumps();
		test_name = "jump";
		prog.delete();
		prog.push_back(enc_i(12'd25, 5'd0, 3'd0, 5'd1, rv_pkg::OPC_OPIMM));
		prog.push_back(enc_j(21'd8, 5'd5));
		prog.push_back(enc_i(12'd1, 5'd0, 3'd0, 5'd7, rv_pkg::OPC_OPIMM)); // Skipped
		prog.push_back(enc_i(12'hffc, 5'd1, 3'd0, 5'd6, rv_pkg::OPC_JALR)); // Odd target 21
		prog.push_back(enc_i(12'd2, 5'd0, 3'd0, 5'd7, rv_pkg::OPC_OPIMM)); // Skipped
		prog.push_back(enc_j(21'd0, 5'd0));
		run_program();
		expect_write(32'd0, 5'd1, 32'd25);
		expect_write(32'd4, 5'd5, 32'd8);
		expect_write(32'd12, 5'd6, 32'd16);
		expect_no_write(32'd20);
	endtask

	task automatic test_upper();
		logic [19:0] u1;
		logic [19:0] u2;
		test_name = "upper";
		u1 = 20'(take_bits(20));
		u2 = 20'(take_bits(20));
		prog.delete();
		prog.push_back(enc_u(u1, 5'd1, rv_pkg::OPC_LUI));
		prog.push_back(enc_u(u2, 5'd2, rv_pkg::OPC_AUIPC));
		prog.push_back(enc_u(u1, 5'd3, rv_pkg::OPC_AUIPC));
		prog.push_back(enc_j(21'd0, 5'd0));
		run_program();
		expect_write(32'd0, 5'd1, {u1, 12'b0});
		expect_write(32'd4, 5'd2, {u2, 12'b0} + 32'd4);
		expect_write(32'd8, 5'd3, {u1, 12'b0} + 32'd8);
	endtask

	task automatic test_zero_reg();
		logic [11:0]   r;
		logic [11:0]   v;
		test_name = "x0";
		r = 12'(take_bits(11)) | 12'd1; // Nonzero value aimed at x0
		v = 12'(take_bits(12));
		prog.delete();
		prog.push_back(enc_i(r, 5'd0, 3'd0, 5'd0, rv_pkg::OPC_OPIMM));
		prog.push_back(enc_i(v, 5'd0, 3'd0, 5'd1, rv_pkg::OPC_OPIMM));
		prog.push_back(enc_r(1'b0, 5'd1, 5'd0, 3'd0, 5'd2));
		prog.push_back(enc_r(1'b0, 5'd0, 5'd1, 3'd0, 5'd3));
		prog.push_back(enc_j(21'd0, 5'd0));
		run_program();
		expect_no_write(32'd0);
		expect_write(32'd4, 5'd1, sext12(v));
		expect_write(32'd8, 5'd2, sext12(v));
		expect_write(32'd12, 5'd3, sext12(v));
	endtask

	// Watchdog allows about 10 cycles per instruction plus load time
	initial begin
		repeat (instr_count * 10 + margin_cycles) @(posedge clock);
		$display("Test failed");
		$fatal(1, "Run timed out waiting for a retire");
	end

	initial begin
		reset     = 1'b1;
		load_en   = 1'b0;
		load_addr = '0;
		load_data = '0;
		test_arith();
		test_memory();
		test_branches();
		test_jumps();
		test_upper();
		test_zero_reg();
		$display("Test completed successfully");
		$finish;
	end

endmodule
